/* include/lsu_ecc_fn.svh */
/*
 * SECDED functions for the DCCM codeword {check[6:0], data[31:0]}
 * Hamming positions 1..38 with data on non-power-of-two positions,
 * plus an overall parity bit in check[6]
 */

// Hamming position of data bit idx
function automatic logic [ECC_W-2:0] ecc_data_pos(input int unsigned idx);
   int unsigned pos;
   int unsigned cnt;
   pos = 0;
   cnt = 0;
   for (int p = 1; p < CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin      // Skip check positions
         if (cnt == idx) pos = p;
         cnt++;
      end
   end
   return (ECC_W-1)'(pos);
endfunction

function automatic logic [ECC_W-1:0] ecc_check_bits(input logic [DATA_W-1:0] data);
   logic [ECC_W-1:0] chk;
   logic [ECC_W-2:0] pos;
   chk = '0;
   for (int j = 0; j < DATA_W; j++) begin
      pos = ecc_data_pos(j);
      for (int b = 0; b < ECC_W - 1; b++) begin
         if (pos[b]) chk[b] ^= data[j];
      end
   end
   chk[ECC_W-1] = ^{data, chk[ECC_W-2:0]};   // Even parity over whole word
   return chk;
endfunction

// Low bits point at the flipped position, top bit is overall parity
function automatic logic [ECC_W-1:0] ecc_syndrome(input logic [CODE_W-1:0] cw);
   logic [ECC_W-1:0] chk;
   logic [ECC_W-1:0] syn;
   chk = ecc_check_bits(cw[DATA_W-1:0]);
   syn[ECC_W-2:0] = chk[ECC_W-2:0] ^ cw[CODE_W-2:DATA_W];
   syn[ECC_W-1]   = ^cw;
   return syn;
endfunction

/* hw/lsu_pkg.sv */
/*
 * Load/store unit shared definitions
 * Widths, access size and exception encodings, and the packed structs that
 * carry requests, pipeline payloads, results and DCCM accesses
 */
`default_nettype none

package lsu_pkg;

   // ************************************************************************
   // Widths and defaults
   // ************************************************************************
   localparam int DATA_W          = 32;                  // Load/store data
   localparam int ECC_W           = 7;                   // Hamming 6 + overall parity
   localparam int CODE_W          = DATA_W + ECC_W;      // Stored codeword
   localparam int DCCM_ADDR_W_DEF = 16;                  // 64 KB window
   localparam int DCCM_WADDR_W    = DCCM_ADDR_W_DEF - 2; // Word address into DCCM
   localparam logic [31:0] DCCM_BASE_DEF = 32'hf004_0000;

   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } lsu_size_e;

   typedef enum logic [1:0] {
      EXC_NONE     = 2'd0,
      EXC_MISALIGN = 2'd1,
      EXC_ACCESS   = 2'd2,   // Outside window or narrow store
      EXC_ECC_DBL  = 2'd3    // Uncorrectable DCCM data
   } lsu_exc_e;

   // ************************************************************************
   // Packets
   // ************************************************************************
   typedef struct packed {
      logic              valid;
      logic              load;
      logic              store;
      lsu_size_e         size;
      logic              unsign;   // Zero extend loads
      logic [31:0]       base;
      logic [11:0]       offset;   // Signed
      logic [DATA_W-1:0] wdata;
   } lsu_req_t;

   typedef struct packed {
      logic      valid;
      logic      load;
      logic      store;
      lsu_size_e size;
      logic      unsign;
   } lsu_ctl_t;

   typedef struct packed {
      lsu_ctl_t    ctl;
      logic [31:0] addr;
      lsu_exc_e    exc;
   } lsu_dc2_t;

   typedef struct packed {
      lsu_ctl_t          ctl;
      logic [31:0]       addr;
      lsu_exc_e          exc;
      logic [CODE_W-1:0] code;     // Codeword read in DC2
   } lsu_dc3_t;

   typedef struct packed {
      logic        exc_valid;
      lsu_exc_e    exc;
      logic        is_store;
      logic [31:0] addr;           // Faulting address
   } lsu_error_t;

   typedef struct packed {
      logic              valid;
      logic              is_load;
      logic [DATA_W-1:0] data;
      lsu_error_t        error;
   } lsu_result_t;

   typedef struct packed {
      logic                    rden;
      logic                    wren;
      logic [DCCM_WADDR_W-1:0] addr;
      logic [CODE_W-1:0]       wdata;  // {check bits, data}
   } dccm_req_t;

endpackage

`default_nettype wire

/* hw/lsu_addr_stage.sv */
/*
 * DC1 stage of the load/store pipe
 * Registers the request, forms the effective address, checks window and
 * alignment, and issues the DCCM read or the ECC-encoded word write
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_stage
   import lsu_pkg::*;
#(
   parameter logic [31:0] DCCM_BASE   = DCCM_BASE_DEF,
   parameter int          DCCM_ADDR_W = DCCM_ADDR_W_DEF
) (
   input  logic      clk,
   input  logic      rst_n,
   input  lsu_req_t  req,
   input  logic      flush,
   output dccm_req_t dccm,
   output lsu_dc2_t  dc2
);

   `include "lsu_ecc_fn.svh"

   logic        dc1_valid;
   lsu_req_t    dc1_q;          // Payload, valid kept apart
   logic [31:0] addr;
   logic        in_window;
   logic        misalign;
   logic        fault;
   lsu_exc_e    exc;
   logic        access_ok;

   // ************************************************************************
   // DC1 register
   // ************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dc1_valid <= 1'b0;
      end else begin
         dc1_valid <= req.valid & ~flush;   // Flush kills the incoming op
      end
   end

   always_ff @(posedge clk) begin
      dc1_q <= req;
   end

   // Base plus sign-extended offset
   assign addr = dc1_q.base + {{20{dc1_q.offset[11]}}, dc1_q.offset};

   assign in_window = (addr[31:DCCM_ADDR_W] == DCCM_BASE[31:DCCM_ADDR_W]);
   assign misalign  = ((dc1_q.size == SIZE_HALF) & addr[0]) |
                      ((dc1_q.size == SIZE_WORD) & (|addr[1:0]));
   // No read-modify-write, so only full words may be stored
   assign fault     = ~in_window | (dc1_q.store & (dc1_q.size != SIZE_WORD));

   always_comb begin
      if (misalign)   exc = EXC_MISALIGN;   // Highest priority
      else if (fault) exc = EXC_ACCESS;
      else            exc = EXC_NONE;
   end

   assign access_ok = dc1_valid & (exc == EXC_NONE);

   // ************************************************************************
   // DCCM access, stores commit here
   // ************************************************************************
   assign dccm.rden  = access_ok & dc1_q.load;
   assign dccm.wren  = access_ok & dc1_q.store;
   assign dccm.addr  = DCCM_WADDR_W'(addr[DCCM_ADDR_W-1:2]);
   assign dccm.wdata = {ecc_check_bits(dc1_q.wdata), dc1_q.wdata};

   // Payload for DC2
   assign dc2.ctl.valid  = dc1_valid;
   assign dc2.ctl.load   = dc1_q.load;
   assign dc2.ctl.store  = dc1_q.store;
   assign dc2.ctl.size   = dc1_q.size;
   assign dc2.ctl.unsign = dc1_q.unsign;
   assign dc2.addr       = addr;
   assign dc2.exc        = exc;

endmodule

`default_nettype wire

/* hw/lsu_stage_reg.sv */
/*
 * Pipeline register for one load/store stage
 * Valid bit is reset and cleared by flush, the payload just follows d
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_stage_reg
   import lsu_pkg::*;
#(
   parameter type payload_t = lsu_dc2_t
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     flush,
   input  payload_t d,
   output payload_t q
);

   logic     vld_q;
   payload_t pay_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= 1'b0;
      end else begin
         vld_q <= d.ctl.valid & ~flush;   // Drop the op on flush
      end
   end

   always_ff @(posedge clk) begin
      pay_q <= d;
   end

   always_comb begin
      q           = pay_q;
      q.ctl.valid = vld_q;                // Controlled copy wins
   end

endmodule

`default_nettype wire

/* hw/lsu_ecc_check.sv */
/*
 * DC3 SECDED checker
 * Decodes the syndrome of the loaded codeword, corrects a single data bit
 * error and flags an uncorrectable double error
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_ecc_check
   import lsu_pkg::*;
(
   input  lsu_dc3_t          dc3,
   output logic [DATA_W-1:0] data_corr,
   output logic              single_err,
   output logic              double_err
);

   `include "lsu_ecc_fn.svh"

   logic [ECC_W-1:0]  syn;
   logic              chk_en;
   logic              syn_nz;
   logic [DATA_W-1:0] flip;

   // Only a clean load actually used the DCCM data
   assign chk_en = dc3.ctl.valid & dc3.ctl.load & (dc3.exc == EXC_NONE);

   assign syn    = ecc_syndrome(dc3.code);
   assign syn_nz = |syn[ECC_W-2:0];

   // ************************************************************************
   // Correction
   // ************************************************************************
   always_comb begin
      flip = '0;
      for (int j = 0; j < DATA_W; j++) begin
         // Parity mismatch means an odd error count, treat as single
         if (ecc_data_pos(j) == syn[ECC_W-2:0]) flip[j] = syn[ECC_W-1];
      end
   end

   assign data_corr = dc3.code[DATA_W-1:0] ^ flip;   // Check bit errors leave data alone

   // Odd parity error, any position including the parity bit itself
   assign single_err = chk_en & syn[ECC_W-1];
   // Even number of flips but the Hamming part still disagrees
   assign double_err = chk_en & ~syn[ECC_W-1] & syn_nz;

endmodule

`default_nettype wire

/* hw/lsu_load_align.sv */
/*
 * DC3 load alignment and result packet
 * Picks the addressed byte or half, extends it, and merges exceptions
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
   import lsu_pkg::*;
(
   input  lsu_dc3_t          dc3,
   input  logic [DATA_W-1:0] data_corr,
   input  logic              single_err,
   input  logic              double_err,
   output lsu_result_t       result,
   output logic              ecc_single_incr
);

   logic [7:0]        byte_sel;
   logic [15:0]       half_sel;
   logic [DATA_W-1:0] ld_data;

   always_comb begin
      case (dc3.addr[1:0])
         2'd0:    byte_sel = data_corr[7:0];
         2'd1:    byte_sel = data_corr[15:8];
         2'd2:    byte_sel = data_corr[23:16];
         default: byte_sel = data_corr[31:24];
      endcase
      half_sel = dc3.addr[1] ? data_corr[31:16] : data_corr[15:0];   // Aligned halves only
   end

   // Sign or zero extension
   always_comb begin
      case (dc3.ctl.size)
         SIZE_BYTE: ld_data = {{24{byte_sel[7] & ~dc3.ctl.unsign}}, byte_sel};
         SIZE_HALF: ld_data = {{16{half_sel[15] & ~dc3.ctl.unsign}}, half_sel};
         default:   ld_data = data_corr;
      endcase
   end

   // ************************************************************************
   // Result packet
   // ************************************************************************
   always_comb begin
      result.valid          = dc3.ctl.valid;
      result.is_load        = dc3.ctl.load;
      result.error.is_store = dc3.ctl.store;
      result.error.addr     = dc3.addr;
      if (dc3.exc != EXC_NONE) begin
         result.error.exc_valid = dc3.ctl.valid;   // Address stage fault first
         result.error.exc       = dc3.exc;
         result.data            = '0;
      end else if (double_err) begin
         result.error.exc_valid = 1'b1;
         result.error.exc       = EXC_ECC_DBL;
         result.data            = '0;
      end else begin
         result.error.exc_valid = 1'b0;
         result.error.exc       = EXC_NONE;
         result.data            = dc3.ctl.load ? ld_data : '0;   // Stores return no data
      end
   end

   // Corrected error counter
   assign ecc_single_incr = single_err & dc3.ctl.valid & dc3.ctl.load &
                            (dc3.exc == EXC_NONE);

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
/*
 * Load/store unit top level
 * Three stage pipe DC1 -> DC2 -> DC3 in front of an ECC protected DCCM,
 * with flush of in-flight loads and an idle indication
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_top
   import lsu_pkg::*;
#(
   parameter logic [31:0] DCCM_BASE   = DCCM_BASE_DEF,
   parameter int          DCCM_ADDR_W = DCCM_ADDR_W_DEF
) (
   input  logic              clk,
   input  logic              rst_n,
   input  lsu_req_t          req,
   input  logic              flush,
   input  logic [CODE_W-1:0] dccm_rdata,   // Valid one cycle after rden
   output dccm_req_t         dccm,
   output lsu_result_t       result,
   output logic              ecc_single_incr,
   output logic              idle
);

   lsu_dc2_t          dc2_d;      // From DC1
   lsu_dc2_t          dc2_q;
   lsu_dc3_t          dc3_d;
   lsu_dc3_t          dc3_q;
   lsu_dc3_t          dc3_live;   // DC3 with flush applied
   logic [DATA_W-1:0] data_corr;
   logic              single_err;
   logic              double_err;

   // ************************************************************************
   // DC1 and pipe registers
   // ************************************************************************
   lsu_addr_stage #(
      .DCCM_BASE   (DCCM_BASE),
      .DCCM_ADDR_W (DCCM_ADDR_W)
   ) u_addr (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .flush (flush),
      .dccm  (dccm),
      .dc2   (dc2_d)
   );

   lsu_stage_reg #(.payload_t(lsu_dc2_t)) u_dc2_reg (
      .clk   (clk),
      .rst_n (rst_n),
      .flush (flush),
      .d     (dc2_d),
      .q     (dc2_q)
   );

   // DC2 codeword joins the payload
   always_comb begin
      dc3_d.ctl  = dc2_q.ctl;
      dc3_d.addr = dc2_q.addr;
      dc3_d.exc  = dc2_q.exc;
      dc3_d.code = dccm_rdata;
   end

   lsu_stage_reg #(.payload_t(lsu_dc3_t)) u_dc3_reg (
      .clk   (clk),
      .rst_n (rst_n),
      .flush (flush),
      .d     (dc3_d),
      .q     (dc3_q)
   );

   // Flush also kills the result leaving this cycle
   always_comb begin
      dc3_live           = dc3_q;
      dc3_live.ctl.valid = dc3_q.ctl.valid & ~flush;
   end

   lsu_ecc_check u_ecc (
      .dc3        (dc3_live),
      .data_corr  (data_corr),
      .single_err (single_err),
      .double_err (double_err)
   );

   lsu_load_align u_align (
      .dc3             (dc3_live),
      .data_corr       (data_corr),
      .single_err      (single_err),
      .double_err      (double_err),
      .result          (result),
      .ecc_single_incr (ecc_single_incr)
   );

   assign idle = ~(dc2_d.ctl.valid | dc2_q.ctl.valid | dc3_q.ctl.valid);   // DC1..DC3 empty

endmodule

`default_nettype wire

/* tests/lsu_dccm_model.sv */
/*
 * Behavioral DCCM for simulation
 * One-cycle read latency, word writes, and a flip mask that corrupts
 * the codeword on its way back to the load/store unit
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_dccm_model
   import lsu_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  dccm_req_t         dccm,
   input  logic [CODE_W-1:0] flip,    // Bits to invert on read data
   output logic [CODE_W-1:0] rdata
);

   logic [CODE_W-1:0] mem [2**DCCM_WADDR_W];   // One codeword per word
   logic [CODE_W-1:0] rd_q;

   // ************************************************************************
   // Write port
   // ************************************************************************
   always_ff @(posedge clk) begin
      if (dccm.wren) begin
         mem[dccm.addr] <= dccm.wdata;            // Check bits come from the DUT
      end
   end

   // Read port, data shows one cycle after rden
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_q <= '0;
      end else if (dccm.rden) begin
         rd_q <= mem[dccm.addr];
      end
   end

   assign rdata = rd_q ^ flip;   // Error injection

endmodule

`default_nettype wire

/* tests/lsu_chk.sv */
/*
 * Protocol assertions on the load/store unit ports
 * Bound into the top level
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_chk (
   input logic clk,
   input logic rst_n,
   input logic req_valid,
   input logic rden,
   input logic wren,
   input logic res_valid,
   input logic incr
);

   // Single ported DCCM
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(rden && wren))
      else $error("DCCM read and write requested in the same cycle");

   // Counter pulse only rides on a result
   a_incr_res: assert property (@(posedge clk) disable iff (!rst_n) incr |-> res_valid)
      else $error("ECC single-error pulse without a result");

   // Fixed three-stage latency
   a_res_req: assert property (@(posedge clk) disable iff (!rst_n)
                               res_valid |-> $past(req_valid, 3))
      else $error("Result without a request three cycles earlier");

endmodule

bind lsu_top lsu_chk chk0 (
   .clk       (clk),
   .rst_n     (rst_n),
   .req_valid (req.valid),
   .rden      (dccm.rden),
   .wren      (dccm.wren),
   .res_valid (result.valid),
   .incr      (ecc_single_incr)
);

`default_nettype wire

/* tests/lsu_tb.sv */
/*
 * Testbench for the load/store unit
 * Word stores and loads, byte/half extension, ECC correction and detection,
 * address exceptions and flush, checked against a shadow memory model
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
   import lsu_pkg::*;
();

   localparam logic [31:0] WIN_BASE = 32'hf004_0000;   // DCCM window
   localparam int          WIN_BITS = 16;
   localparam int          TIMEOUT  = 50;               // Cycles per wait

   typedef struct {
      int unsigned due;    // Cycle count when the result must show
      lsu_result_t res;
      logic        incr;
   } expect_t;

   logic              clk;
   logic              rst_n;
   lsu_req_t          req;
   logic              flush;
   logic [CODE_W-1:0] flip;        // Read data corruption
   logic [CODE_W-1:0] dccm_rdata;
   dccm_req_t         dccm;
   lsu_result_t       result;
   logic              ecc_single_incr;
   logic              idle;

   int unsigned       cyc = 0;
   logic [15:0]       lfsr = 16'd8958;
   logic [31:0]       shadow [int unsigned];   // Stored words by word index
   expect_t           exp_q[$];

   lsu_top #(
      .DCCM_BASE   (WIN_BASE),
      .DCCM_ADDR_W (WIN_BITS)
   ) dut0 (
      .clk             (clk),
      .rst_n           (rst_n),
      .req             (req),
      .flush           (flush),
      .dccm_rdata      (dccm_rdata),
      .dccm            (dccm),
      .result          (result),
      .ecc_single_incr (ecc_single_incr),
      .idle            (idle)
   );

   lsu_dccm_model mem0 (
      .clk   (clk),
      .rst_n (rst_n),
      .dccm  (dccm),
      .flip  (flip),
      .rdata (dccm_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   // ************************************************************************
   // Random source and reference model
   // ************************************************************************
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Random offset, base chosen so that the sum hits addr
   function automatic lsu_req_t make_req(input logic ld, input logic st, input lsu_size_e sz,
                                         input logic uns, input logic [31:0] addr,
                                         input logic [31:0] wd);
      lsu_req_t    r;
      logic [11:0] off;
      off      = 12'(rand_bits(12));
      r        = '0;
      r.valid  = 1'b1;
      r.load   = ld;
      r.store  = st;
      r.size   = sz;
      r.unsign = uns;
      r.offset = off;
      r.base   = addr - {{20{off[11]}}, off};
      r.wdata  = wd;
      return r;
   endfunction

   function automatic lsu_result_t ref_result(input lsu_req_t r, input logic [CODE_W-1:0] fl,
                                              output logic incr);
      lsu_result_t res;
      logic [31:0] a;
      logic [31:0] w;
      logic [7:0]  b8;
      logic [15:0] h16;
      int          nflip;
      lsu_exc_e    exc;
      a     = r.base + {{20{r.offset[11]}}, r.offset};
      nflip = $countones(fl);
      incr  = 1'b0;
      if ((r.size == SIZE_HALF && a[0]) || (r.size == SIZE_WORD && a[1:0] != 2'b00))
         exc = EXC_MISALIGN;
      else if (a[31:WIN_BITS] != WIN_BASE[31:WIN_BITS] || (r.store && r.size != SIZE_WORD))
         exc = EXC_ACCESS;
      else if (r.load && nflip == 2)
         exc = EXC_ECC_DBL;                       // Detected, not corrected
      else
         exc = EXC_NONE;
      res                 = '0;
      res.valid           = 1'b1;
      res.is_load         = r.load;
      res.error.exc_valid = (exc != EXC_NONE);
      res.error.exc       = exc;
      res.error.is_store  = r.store;
      res.error.addr      = a;
      if (exc == EXC_NONE && r.load) begin
         w    = shadow[a[WIN_BITS-1:2]];          // Single flips come back corrected
         incr = (nflip == 1);
         b8   = w[8*a[1:0] +: 8];
         h16  = w[16*a[1] +: 16];
         case (r.size)
            SIZE_BYTE: res.data = r.unsign ? 32'(b8) : 32'(signed'(b8));
            SIZE_HALF: res.data = r.unsign ? 32'(h16) : 32'(signed'(h16));
            default:   res.data = w;
         endcase
      end
      return res;
   endfunction

   // ************************************************************************
   // Checks
   // ************************************************************************
   task automatic end_with_failure();
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_error(input lsu_error_t got, input lsu_error_t exp);
      if (got !== exp) begin
         $display("[ERROR] result.error got %h expected %h", got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_result(input lsu_result_t got, input lsu_result_t exp);
      check_bit("result.valid", got.valid, exp.valid);
      check_bit("result.is_load", got.is_load, exp.is_load);
      if (got.data !== exp.data) begin
         $display("[ERROR] result.data got %h expected %h", got.data, exp.data);
         end_with_failure();
      end
      check_error(got.error, exp.error);
   endtask

   // Compare process, one look per cycle where outputs are settled
   initial begin : compare
      expect_t e;
      forever begin
         @(negedge clk);
         if (rst_n) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
               e = exp_q.pop_front();
               check_result(result, e.res);
               check_bit("ecc_single_incr", ecc_single_incr, e.incr);
            end else begin
               check_bit("result.valid", result.valid, 1'b0);   // Nothing due
               check_bit("ecc_single_incr", ecc_single_incr, 1'b0);
            end
         end
      end
   end

   // ************************************************************************
   // Stimulus tasks
   // ************************************************************************
   task automatic drive_req(input lsu_req_t r, input logic [CODE_W-1:0] fl);
      expect_t e;
      logic    inc;
      @(posedge clk);
      req    <= r;
      flip   <= fl;                 // Held until the next request
      e.res  = ref_result(r, fl, inc);
      e.incr = inc;
      e.due  = cyc + 4;             // Sampled next edge, result three cycles on
      exp_q.push_back(e);
      if (r.store && !e.res.error.exc_valid) shadow[e.res.error.addr[WIN_BITS-1:2]] = r.wdata;
   endtask

   // Stop requests and wait for an empty pipe
   task automatic drain();
      int n;
      n = 0;
      @(posedge clk);
      req <= '0;
      do begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT) begin
            $display("Pipeline did not go idle within %0d cycles", TIMEOUT);
            end_with_failure();
         end
      end while (!idle);
      if (exp_q.size() != 0) begin
         $display("Pipeline went idle with %0d results still missing", exp_q.size());
         end_with_failure();
      end
   endtask

   // Faulting request must not touch the DCCM in its DC1 cycle
   task automatic issue_faulty(input lsu_req_t r);
      drive_req(r, '0);
      @(posedge clk);
      req <= '0;
      @(negedge clk);
      check_bit("dccm.rden", dccm.rden, 1'b0);
      check_bit("dccm.wren", dccm.wren, 1'b0);
   endtask

   // ************************************************************************
   // Main sequence
   // ************************************************************************
   initial begin : stimulus
      logic [31:0]       a;
      logic [31:0]       d;
      logic [CODE_W-1:0] fl;
      int unsigned       p0;
      int unsigned       p1;
      logic [31:0]       addrs[$];
      req   = '0;
      flush = 1'b0;
      flip  = '0;
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_bit("idle", idle, 1'b1);
      check_bit("dccm.rden", dccm.rden, 1'b0);
      check_bit("dccm.wren", dccm.wren, 1'b0);

      // Word stores then word loads
      for (int i = 0; i < 16; i++) begin
         a = WIN_BASE + (rand_bits(WIN_BITS - 2) << 2);
         d = rand_bits(32);
         addrs.push_back(a);
         drive_req(make_req(1'b0, 1'b1, SIZE_WORD, 1'b0, a, d), '0);
      end
      foreach (addrs[i]) drive_req(make_req(1'b1, 1'b0, SIZE_WORD, 1'b0, addrs[i], '0), '0);
      drain();

      // Byte and half loads, signed and unsigned
      for (int i = 0; i < 4; i++) begin
         for (int b = 0; b < 4; b++) begin
            drive_req(make_req(1'b1, 1'b0, SIZE_BYTE, 1'b0, addrs[i] + b, '0), '0);
            drive_req(make_req(1'b1, 1'b0, SIZE_BYTE, 1'b1, addrs[i] + b, '0), '0);
         end
         for (int h = 0; h < 4; h += 2) begin
            drive_req(make_req(1'b1, 1'b0, SIZE_HALF, 1'b0, addrs[i] + h, '0), '0);
            drive_req(make_req(1'b1, 1'b0, SIZE_HALF, 1'b1, addrs[i] + h, '0), '0);
         end
      end
      drain();

      // Single-bit errors are corrected
      for (int i = 0; i < 10; i++) begin
         p0     = rand_bits(6) % CODE_W;
         fl     = '0;
         fl[p0] = 1'b1;
         drive_req(make_req(1'b1, 1'b0, SIZE_WORD, 1'b0, addrs[i], '0), fl);
         drain();
      end

      // Double-bit errors raise an exception
      for (int i = 0; i < 8; i++) begin
         p0     = rand_bits(6) % CODE_W;
         p1     = (p0 + 1 + rand_bits(6) % (CODE_W - 1)) % CODE_W;   // Distinct bit
         fl     = '0;
         fl[p0] = 1'b1;
         fl[p1] = 1'b1;
         drive_req(make_req(1'b1, 1'b0, SIZE_WORD, 1'b0, addrs[i], '0), fl);
         drain();
      end

      // Address exceptions
      issue_faulty(make_req(1'b1, 1'b0, SIZE_WORD, 1'b0, addrs[0] + 2, '0));
      issue_faulty(make_req(1'b1, 1'b0, SIZE_HALF, 1'b1, addrs[1] + 1, '0));
      issue_faulty(make_req(1'b0, 1'b1, SIZE_WORD, 1'b0, addrs[2] + 1, 32'h1234_5678));
      issue_faulty(make_req(1'b1, 1'b0, SIZE_WORD, 1'b0, WIN_BASE + 32'h0001_0000, '0));
      issue_faulty(make_req(1'b1, 1'b0, SIZE_BYTE, 1'b0, WIN_BASE - 4, '0));
      issue_faulty(make_req(1'b1, 1'b0, SIZE_WORD, 1'b0, WIN_BASE - 3, '0));   // Misalign wins
      issue_faulty(make_req(1'b0, 1'b1, SIZE_BYTE, 1'b0, addrs[3], 32'hdead_beef));
      issue_faulty(make_req(1'b0, 1'b1, SIZE_HALF, 1'b0, addrs[4] + 2, 32'h0bad_f00d));
      drain();

      // Flush with loads in flight
      for (int i = 0; i < 3; i++) begin
         drive_req(make_req(1'b1, 1'b0, SIZE_WORD, 1'b0, addrs[i], '0), '0);
      end
      @(posedge clk);
      flush <= 1'b1;
      req   <= '0;
      exp_q.delete();               // All three are killed
      @(posedge clk);
      req   <= make_req(1'b1, 1'b0, SIZE_WORD, 1'b0, addrs[5], '0);   // Dropped on entry
      @(posedge clk);
      req   <= '0;
      @(posedge clk);
      flush <= 1'b0;
      drain();

      // Normal traffic after the flush
      d = rand_bits(32);
      drive_req(make_req(1'b0, 1'b1, SIZE_WORD, 1'b0, addrs[6], d), '0);
      for (int i = 5; i < 9; i++) begin
         drive_req(make_req(1'b1, 1'b0, SIZE_WORD, 1'b0, addrs[i], '0), '0);
      end
      drain();

      if (exp_q.size() == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("TEST FAILED");
         $fatal(1, "Results left over at the end of the run");
      end
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
hw/lsu_pkg.sv
hw/lsu_addr_stage.sv
hw/lsu_stage_reg.sv
hw/lsu_ecc_check.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
tests/lsu_dccm_model.sv
tests/lsu_chk.sv
tests/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_dccm

sources:
  # Synthesizable load/store pipe
  - include_dirs:
      - include
    files:
      - hw/lsu_pkg.sv
      - hw/lsu_addr_stage.sv
      - hw/lsu_stage_reg.sv
      - hw/lsu_ecc_check.sv
      - hw/lsu_load_align.sv
      - hw/lsu_top.sv

  # Simulation only
  - target: test
    files:
      - tests/lsu_dccm_model.sv
      - tests/lsu_chk.sv
      - tests/lsu_tb.sv
